/* parallel_accumulator.f */
+incdir+.
scan_pkg.sv
vertex_pkg.sv
seg_scan_level.sv
seg_scan_tree.sv
sideband_delay.sv
segment_output.sv
parallel_accumulator.sv
parallel_accumulator_assertions.sv
parallel_accumulator_tb.sv

/* parallel_accumulator.sv */
// segmented lane reduction, SCAN_LATENCY cycles, one input set per cycle and no back-pressure
`timescale 1ns/1ps
`include "seg_scan_defines.svh"

module parallel_accumulator (
    input  logic                   clk,
    input  logic                   rst,
    // lane data, equal ids must be in adjacent lanes
    input  scan_pkg::lane_values_t in_values,
    input  scan_pkg::lane_ids_t    in_ids,
    input  logic                   in_valid,
    // destination sideband
    input  vertex_pkg::dst_ids_t   in_dst_ids,
    input  vertex_pkg::src_masks_t in_src_masks,
    input  vertex_pkg::chan_bits_t in_dst_valid,
    output scan_pkg::lane_values_t sums,
    output scan_pkg::lane_ids_t    out_ids,
    output scan_pkg::lane_mask_t   seg_end,
    output logic                   out_valid,
    output vertex_pkg::dst_ids_t   out_dst_ids,
    output vertex_pkg::src_masks_t out_src_masks,
    output vertex_pkg::chan_bits_t out_dst_valid
);

    import scan_pkg::*;

    lane_values_t scan_values;
    lane_ids_t    scan_ids;
    logic         dly_valid;

    seg_scan_tree scan_tree_i (
        .clk(clk),
        .rst(rst),
        .in_values(in_values),
        .in_ids(in_ids),
        .scan_values(scan_values),
        .scan_ids(scan_ids)
    );

    // runs beside the scan tree
    sideband_delay sideband_delay_i (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_dst_ids(in_dst_ids),
        .in_src_masks(in_src_masks),
        .in_dst_valid(in_dst_valid),
        .dly_valid(dly_valid),
        .out_dst_ids(out_dst_ids),
        .out_src_masks(out_src_masks),
        .out_dst_valid(out_dst_valid)
    );

    segment_output segment_output_i (
        .clk(clk),
        .rst(rst),
        .scan_values(scan_values),
        .scan_ids(scan_ids),
        .dly_valid(dly_valid),
        .sums(sums),
        .out_ids(out_ids),
        .seg_end(seg_end),
        .out_valid(out_valid)
    );

endmodule

/* parallel_accumulator_assertions.sv */
// checks on out_valid and seg_end only; fail_count is read back by the testbench at the end
`timescale 1ns/1ps
`include "seg_scan_defines.svh"

module parallel_accumulator_assertions (
    input logic                 clk,
    input logic                 rst,
    input logic                 in_valid,
    input logic                 out_valid,
    input scan_pkg::lane_mask_t seg_end
);

    import scan_pkg::*;

    localparam lane_mask_t no_lanes = '0;

    int fail_count = 0;

    // no run can close on an idle beat
    a_seg_end_idle: assert property (
        @(posedge clk) disable iff (rst) !out_valid |-> seg_end == no_lanes
    ) else begin
        fail_count++;
        $error("seg_end set while out_valid is low");
    end

    a_last_lane_end: assert property (
        @(posedge clk) disable iff (rst) seg_end[`LANE_NUM-1] == out_valid
    ) else begin
        fail_count++;
        $error("last lane seg_end does not follow out_valid");
    end

    // fixed pipeline depth, nothing stalls
    a_valid_latency: assert property (
        @(posedge clk) disable iff (rst) out_valid == $past(in_valid, `SCAN_LATENCY)
    ) else begin
        fail_count++;
        $error("out_valid does not match in_valid from SCAN_LATENCY cycles earlier");
    end

endmodule

bind parallel_accumulator parallel_accumulator_assertions assertions_i (
    .clk(clk),
    .rst(rst),
    .in_valid(in_valid),
    .out_valid(out_valid),
    .seg_end(seg_end)
);

/* parallel_accumulator_tb.sv */
// directed regression; expected sums and seg_end come from a software model of the scan rules
`timescale 1ns/1ps
`include "seg_scan_defines.svh"

module parallel_accumulator_tb;

    import scan_pkg::*;
    import vertex_pkg::*;

    typedef struct {
        lane_values_t sums;
        lane_ids_t    ids;
        lane_mask_t   seg;
        dst_ids_t     dst_ids;
        src_masks_t   masks;
        chan_bits_t   dvalid;
        int           cycle;
    } expect_t;

    logic         clk;
    logic         rst;
    lane_values_t in_values;
    lane_ids_t    in_ids;
    logic         in_valid;
    dst_ids_t     in_dst_ids;
    src_masks_t   in_src_masks;
    chan_bits_t   in_dst_valid;
    lane_values_t sums;
    lane_ids_t    out_ids;
    lane_mask_t   seg_end;
    logic         out_valid;
    dst_ids_t     out_dst_ids;
    src_masks_t   out_src_masks;
    chan_bits_t   out_dst_valid;

    expect_t     expect_q[$];
    expect_t     mon_exp;
    logic [15:0] lfsr_state;
    int          cycle = 0;
    int          check_errors = 0;
    int          timeout_errors = 0;
    int          assert_errors = 0;

    parallel_accumulator parallel_accumulator_i (
        .clk(clk),
        .rst(rst),
        .in_values(in_values),
        .in_ids(in_ids),
        .in_valid(in_valid),
        .in_dst_ids(in_dst_ids),
        .in_src_masks(in_src_masks),
        .in_dst_valid(in_dst_valid),
        .sums(sums),
        .out_ids(out_ids),
        .seg_end(seg_end),
        .out_valid(out_valid),
        .out_dst_ids(out_dst_ids),
        .out_src_masks(out_src_masks),
        .out_dst_valid(out_dst_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t ns: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // lane i sums every lane j <= i that carries the same id
    function automatic lane_values_t model_sums(input lane_values_t v, input lane_ids_t d);
        lane_values_t r;
        for (int i = 0; i < `LANE_NUM; i++) begin
            r[i] = '0;
            for (int j = 0; j <= i; j++) begin
                if (d[j] == d[i]) begin
                    r[i] = r[i] + v[j];
                end
            end
        end
        return r;
    endfunction

    function automatic lane_mask_t model_seg_end(input lane_ids_t d);
        lane_mask_t r;
        for (int i = 0; i < `LANE_NUM; i++) begin
            if (i == `LANE_NUM - 1) begin
                r[i] = 1'b1;
            end else begin
                r[i] = (d[i + 1] != d[i]);
            end
        end
        return r;
    endfunction

    task automatic drive_beat(input lane_values_t v, input lane_ids_t d, input dst_ids_t di,
                              input src_masks_t m, input chan_bits_t dv);
        expect_t e;
        @(posedge clk);
        #1;
        in_values    = v;
        in_ids       = d;
        in_valid     = 1'b1;
        in_dst_ids   = di;
        in_src_masks = m;
        in_dst_valid = dv;
        e.sums    = model_sums(v, d);
        e.ids     = d;
        e.seg     = model_seg_end(d);
        e.dst_ids = di;
        e.masks   = m;
        e.dvalid  = dv;
        // sampled at the next edge, registered out SCAN_LATENCY edges from now
        e.cycle   = cycle + `SCAN_LATENCY;
        expect_q.push_back(e);
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #1;
        in_valid     = 1'b0;
        in_dst_valid = '0;
    endtask

    task automatic wait_drained(input string test_name);
        int n;
        n = 0;
        while (expect_q.size() != 0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (expect_q.size() != 0) begin
            timeout_errors++;
            $display("TIMEOUT in %s test: %0d expected results never appeared on out_valid",
                     test_name, expect_q.size());
            expect_q.delete();
        end
    endtask

    task automatic random_sideband(output dst_ids_t di, output src_masks_t m,
                                   output chan_bits_t dv);
        logic [31:0] r;
        for (int c = 0; c < `DST_CHAN_NUM; c++) begin
            rand_bits(16, r);
            di[c] = r[15:0];
            rand_bits(16, r);
            m[c] = r[15:0];
        end
        rand_bits(4, r);
        dv = r[3:0];
    endtask

    // compare every result beat against the oldest outstanding expectation
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            if (expect_q.size() == 0) begin
                check_errors++;
                $display("unexpected result on out_valid at %0t ns with nothing outstanding",
                         $time);
            end else begin
                mon_exp = expect_q.pop_front();
                compare("out_valid cycle", 32'(cycle), 32'(mon_exp.cycle));
                for (int i = 0; i < `LANE_NUM; i++) begin
                    compare($sformatf("sums[%0d]", i), sums[i], mon_exp.sums[i]);
                    compare($sformatf("out_ids[%0d]", i), 32'(out_ids[i]), 32'(mon_exp.ids[i]));
                end
                compare("seg_end", 32'(seg_end), 32'(mon_exp.seg));
                for (int c = 0; c < `DST_CHAN_NUM; c++) begin
                    compare($sformatf("out_dst_ids[%0d]", c), 32'(out_dst_ids[c]),
                            32'(mon_exp.dst_ids[c]));
                    compare($sformatf("out_src_masks[%0d]", c), 32'(out_src_masks[c]),
                            32'(mon_exp.masks[c]));
                end
                compare("out_dst_valid", 32'(out_dst_valid), 32'(mon_exp.dvalid));
            end
        end
    end

    task automatic check_quiet_outputs();
        compare("out_valid", 32'(out_valid), 32'd0);
        compare("seg_end", 32'(seg_end), 32'd0);
        compare("out_dst_valid", 32'(out_dst_valid), 32'd0);
    endtask

    task automatic test_reset();
        for (int n = 0; n < 3; n++) begin
            @(negedge clk);
            check_quiet_outputs();
        end
        // fourth edge with rst high
        @(posedge clk);
        #1;
        rst = 1'b0;
        for (int n = 0; n < 2; n++) begin
            @(negedge clk);
            check_quiet_outputs();
        end
    endtask

    task automatic test_distinct_ids();
        lane_values_t v;
        lane_ids_t    d;
        logic [31:0]  r;
        for (int b = 0; b < 3; b++) begin
            for (int i = 0; i < `LANE_NUM; i++) begin
                rand_bits(32, r);
                v[i] = r;
                d[i] = 4'(i);
            end
            drive_beat(v, d, '0, '0, '0);
        end
        drive_idle();
        wait_drained("distinct ids");
    endtask

    task automatic test_single_run();
        lane_values_t v;
        lane_ids_t    d;
        // large values so the running sum wraps from the second lane on
        for (int i = 0; i < `LANE_NUM; i++) begin
            v[i] = 32'h9000_0000 + 32'(i);
            d[i] = 4'd7;
        end
        drive_beat(v, d, '0, '0, '0);
        drive_idle();
        wait_drained("single run");
    endtask

    task automatic test_random_runs();
        lane_values_t v;
        lane_ids_t    d;
        acc_id_t      id;
        dst_ids_t     di;
        src_masks_t   m;
        chan_bits_t   dv;
        logic [31:0]  r;
        for (int b = 0; b < 24; b++) begin
            id = '0;
            for (int i = 0; i < `LANE_NUM; i++) begin
                if (i != 0) begin
                    rand_bits(1, r);
                    id = id + acc_id_t'(r[0]);
                end
                d[i] = id;
                rand_bits(32, r);
                v[i] = r;
            end
            random_sideband(di, m, dv);
            drive_beat(v, d, di, m, dv);
            rand_bits(2, r);
            if (r[1:0] == 2'b00) begin
                drive_idle();
            end
        end
        drive_idle();
        wait_drained("random runs");
    endtask

    task automatic test_sideband();
        dst_ids_t   di;
        src_masks_t m;
        chan_bits_t dv;
        for (int b = 0; b < 6; b++) begin
            random_sideband(di, m, dv);
            drive_beat('0, '0, di, m, dv);
        end
        drive_idle();
        wait_drained("sideband");
    endtask

    initial begin
        lfsr_state   = 16'd58857;
        rst          = 1'b1;
        in_values    = '0;
        in_ids       = '0;
        in_valid     = 1'b0;
        in_dst_ids   = '0;
        in_src_masks = '0;
        in_dst_valid = '0;
        test_reset();
        test_distinct_ids();
        test_single_run();
        test_random_runs();
        test_sideband();
        repeat (2) @(posedge clk);
        assert_errors = parallel_accumulator_i.assertions_i.fail_count;
        $display("errors: %0d check, %0d timeout, %0d assertion",
                 check_errors, timeout_errors, assert_errors);
        if (check_errors + timeout_errors + assert_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the regression with Verilator; the exit status follows the simulation log

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log
rm -f "$build_log" "$sim_log"

verilator --binary --timing --assert -Wno-fatal \
    --top-module parallel_accumulator_tb \
    -f parallel_accumulator.f \
    -o sim_parallel_accumulator > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$build_log"
    echo "verilator build failed with status $status"
    exit 1
fi

# keep running after an assertion error so the testbench can report
./obj_dir/sim_parallel_accumulator +verilator+error+limit+1000 > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" "$sim_log"; then
    exit 0
fi
echo "pass message not found in $sim_log"
exit 1

/* scan_pkg.sv */
// lane types for the reduction path; values are unsigned and sums wrap modulo 2^VALUE_WIDTH
`include "seg_scan_defines.svh"

package scan_pkg;

    // one lane
    typedef logic [`VALUE_WIDTH-1:0]  value_t;
    typedef logic [`ACC_ID_WIDTH-1:0] acc_id_t;

    // all lanes of one cycle, lane 0 in the low slot
    typedef value_t  [`LANE_NUM-1:0] lane_values_t;
    typedef acc_id_t [`LANE_NUM-1:0] lane_ids_t;

    // one flag per lane
    typedef logic [`LANE_NUM-1:0] lane_mask_t;

endpackage

/* seg_scan_defines.svh */
// sizes fixed at 16 lanes, so LEVEL_NUM must stay log2(LANE_NUM) and SCAN_LATENCY = LEVEL_NUM + 1
`ifndef SEG_SCAN_DEFINES_SVH
`define SEG_SCAN_DEFINES_SVH

// lane data path
`define LANE_NUM       16
`define LEVEL_NUM      4
`define VALUE_WIDTH    32
`define ACC_ID_WIDTH   4

// destination sideband
`define DST_CHAN_NUM   4
`define DST_ID_WIDTH   16
`define MASK_WIDTH     16

// four scan levels plus the output register
`define SCAN_LATENCY   5

`endif

/* seg_scan_level.sv */
// one scan level, one cycle; correct only when equal ids sit in contiguous lanes
`timescale 1ns/1ps
`include "seg_scan_defines.svh"

module seg_scan_level #(
    parameter int level = 0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  scan_pkg::lane_values_t in_values,
    input  scan_pkg::lane_ids_t    in_ids,
    output scan_pkg::lane_values_t out_values,
    output scan_pkg::lane_ids_t    out_ids
);

    import scan_pkg::*;

    lane_values_t next_values;

    // blocks of 2^(level+1) lanes; the upper half looks back at the lower half's last lane
    for (genvar i = 0; i < `LANE_NUM; i++) begin : g_lane
        if (((i >> level) & 1) == 1) begin : g_upper
            localparam int partner = ((i >> level) << level) - 1;

            value_t partner_value;
            value_t own_value;
            logic   same_run;

            assign partner_value = in_values[partner];
            assign own_value     = in_values[i];
            assign same_run      = (in_ids[partner] == in_ids[i]);

            // plain wrapping add
            assign next_values[i] = same_run ? own_value + partner_value : own_value;
        end else begin : g_lower
            // lower half already holds its partial sum
            assign next_values[i] = in_values[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_values <= '0;
            out_ids    <= '0;
        end else begin
            out_values <= next_values;
            // ids ride along unchanged
            out_ids    <= in_ids;
        end
    end

endmodule

/* seg_scan_tree.sv */
// LEVEL_NUM chained scan levels, LEVEL_NUM cycles deep, no stall
`timescale 1ns/1ps
`include "seg_scan_defines.svh"

module seg_scan_tree (
    input  logic                   clk,
    input  logic                   rst,
    input  scan_pkg::lane_values_t in_values,
    input  scan_pkg::lane_ids_t    in_ids,
    output scan_pkg::lane_values_t scan_values,
    output scan_pkg::lane_ids_t    scan_ids
);

    import scan_pkg::*;

    // stage 0 is the raw input, stage LEVEL_NUM the finished scan
    lane_values_t stage_values [`LEVEL_NUM + 1];
    lane_ids_t    stage_ids    [`LEVEL_NUM + 1];

    assign stage_values[0] = in_values;
    assign stage_ids[0]    = in_ids;

    for (genvar k = 0; k < `LEVEL_NUM; k++) begin : g_level
        seg_scan_level #(
            .level(k)
        ) level_i (
            .clk(clk),
            .rst(rst),
            .in_values(stage_values[k]),
            .in_ids(stage_ids[k]),
            .out_values(stage_values[k + 1]),
            .out_ids(stage_ids[k + 1])
        );
    end

    assign scan_values = stage_values[`LEVEL_NUM];
    assign scan_ids    = stage_ids[`LEVEL_NUM];

endmodule

/* segment_output.sv */
// final register stage; seg_end trusts the contiguous-id precondition and does not check it
`timescale 1ns/1ps
`include "seg_scan_defines.svh"

module segment_output (
    input  logic                   clk,
    input  logic                   rst,
    input  scan_pkg::lane_values_t scan_values,
    input  scan_pkg::lane_ids_t    scan_ids,
    input  logic                   dly_valid,
    output scan_pkg::lane_values_t sums,
    output scan_pkg::lane_ids_t    out_ids,
    output scan_pkg::lane_mask_t   seg_end,
    output logic                   out_valid
);

    import scan_pkg::*;

    lane_mask_t run_last;
    lane_mask_t next_seg_end;

    // a lane closes its run when the next lane starts another id
    always_comb begin
        for (int i = 0; i < `LANE_NUM - 1; i++) begin
            run_last[i] = (scan_ids[i + 1] != scan_ids[i]);
        end
        // top lane always ends whatever run it is in
        run_last[`LANE_NUM - 1] = 1'b1;
    end

    assign next_seg_end = dly_valid ? run_last : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            sums      <= '0;
            out_ids   <= '0;
            seg_end   <= '0;
            out_valid <= 1'b0;
        end else begin
            sums      <= scan_values;
            out_ids   <= scan_ids;
            seg_end   <= next_seg_end;
            out_valid <= dly_valid;
        end
    end

endmodule

/* sideband_delay.sv */
// fixed delay of SCAN_LATENCY cycles for the destination channels, the valid tap one stage earlier
`timescale 1ns/1ps
`include "seg_scan_defines.svh"

module sideband_delay (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  vertex_pkg::dst_ids_t   in_dst_ids,
    input  vertex_pkg::src_masks_t in_src_masks,
    input  vertex_pkg::chan_bits_t in_dst_valid,
    output logic                   dly_valid,
    output vertex_pkg::dst_ids_t   out_dst_ids,
    output vertex_pkg::src_masks_t out_src_masks,
    output vertex_pkg::chan_bits_t out_dst_valid
);

    import vertex_pkg::*;

    localparam int data_depth  = `SCAN_LATENCY;
    // the last valid stage lives in segment_output
    localparam int valid_depth = `SCAN_LATENCY - 1;

    logic [valid_depth-1:0] valid_pipe;

    dst_ids_t   dst_ids_pipe   [data_depth];
    src_masks_t src_masks_pipe [data_depth];
    chan_bits_t dst_valid_pipe [data_depth];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
            for (int s = 0; s < data_depth; s++) begin
                dst_ids_pipe[s]   <= '0;
                src_masks_pipe[s] <= '0;
                dst_valid_pipe[s] <= '0;
            end
        end else begin
            valid_pipe        <= {valid_pipe[valid_depth-2:0], in_valid};
            dst_ids_pipe[0]   <= in_dst_ids;
            src_masks_pipe[0] <= in_src_masks;
            dst_valid_pipe[0] <= in_dst_valid;
            for (int s = 1; s < data_depth; s++) begin
                dst_ids_pipe[s]   <= dst_ids_pipe[s - 1];
                src_masks_pipe[s] <= src_masks_pipe[s - 1];
                dst_valid_pipe[s] <= dst_valid_pipe[s - 1];
            end
        end
    end

    assign dly_valid     = valid_pipe[valid_depth-1];
    assign out_dst_ids   = dst_ids_pipe[data_depth-1];
    assign out_src_masks = src_masks_pipe[data_depth-1];
    assign out_dst_valid = dst_valid_pipe[data_depth-1];

endmodule

/* vertex_pkg.sv */
// destination sideband types; the payload is carried as is and never inspected
`include "seg_scan_defines.svh"

package vertex_pkg;

    typedef logic [`DST_ID_WIDTH-1:0] dst_id_t;
    typedef logic [`MASK_WIDTH-1:0]   src_mask_t;

    // one entry per destination channel
    typedef dst_id_t   [`DST_CHAN_NUM-1:0] dst_ids_t;
    typedef src_mask_t [`DST_CHAN_NUM-1:0] src_masks_t;
    typedef logic      [`DST_CHAN_NUM-1:0] chan_bits_t;

endpackage
